// ==== logic/rm_pkg.sv ====
// Runtime memory monitor definitions
`default_nettype none

package rm_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	// Monitor lanes, one outstanding access each
	localparam int unsigned RM_NUM_LANES = 4;
	localparam int unsigned RM_LANE_W = 2;

	// Address and counter widths
	localparam int unsigned RM_VLEN = 32;
	localparam int unsigned RM_TIMER_W = 16;
	localparam int unsigned RM_CNT_W = 16;

	// Register port data width
	localparam int unsigned RM_DATA_W = 32;

	// Timeout after reset, in cycles
	localparam logic [RM_TIMER_W-1:0] RM_TIMEOUT_DEF = 16'd8;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// RISC-V major opcodes seen at issue
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_BRANCH = 7'b1100011
	} rm_opcode_e;

	// Register map
	typedef enum logic [2:0] {
		REG_CTRL     = 3'd0,
		REG_TIMEOUT  = 3'd1,
		REG_VIOL_CNT = 3'd2,
		REG_DROP_CNT = 3'd3,
		REG_LAST_PC  = 3'd4
	} rm_reg_e;

	//////////////////////////////
	// Structs
	//////////////////////////////

	// Allocation result for the issuing instruction
	typedef struct packed {
		logic                 monitor_ins;
		logic [RM_LANE_W-1:0] lane;
	} rm_monitor_t;

	// One lane release, from response or timeout
	typedef struct packed {
		logic                 reset_lane;
		logic [RM_LANE_W-1:0] lane;
		logic                 timeout;
	} rm_release_t;

	// Monitor configuration
	typedef struct packed {
		logic                  enable;
		logic                  mon_load;
		logic                  mon_store;
		logic [RM_TIMER_W-1:0] timeout;
	} rm_cfg_t;

endpackage

`default_nettype wire

// ==== logic/rm_lane_allocator.sv ====
// Monitor lane allocator
`timescale 1ns/1ns
`default_nettype none

module rm_lane_allocator (
	input  wire                                           clk_i,
	input  wire                                           rst_ni,
	input  rm_pkg::rm_opcode_e                            opcode_i,
	input  wire [rm_pkg::RM_VLEN-1:0]                     pc_i,
	input  wire                                           entry_queued_i,
	input  rm_pkg::rm_cfg_t                               cfg_i,
	input  rm_pkg::rm_release_t [rm_pkg::RM_NUM_LANES-1:0] release_i,
	output rm_pkg::rm_monitor_t                           monitor_o,
	output logic [rm_pkg::RM_NUM_LANES-1:0]               lane_busy_o,
	output logic [rm_pkg::RM_NUM_LANES-1:0][rm_pkg::RM_VLEN-1:0] lane_pc_o,
	output logic                                          drop_o
);
	import rm_pkg::*;

	// Per-lane state
	logic [RM_NUM_LANES-1:0]              busy_q;
	logic [RM_NUM_LANES-1:0][RM_VLEN-1:0] pc_q;

	// Issue decode
	logic                 is_monitored;
	logic                 any_free;
	logic [RM_LANE_W-1:0] free_lane;
	logic                 alloc;

	//////////////////////////////
	// Filter and lane pick
	//////////////////////////////

	always_comb begin
		// Queued, globally enabled, and its class enabled
		is_monitored = entry_queued_i && cfg_i.enable &&
			((opcode_i == OPC_LOAD && cfg_i.mon_load) ||
			 (opcode_i == OPC_STORE && cfg_i.mon_store));

		// Walk down so the lowest free lane wins
		any_free  = 1'b0;
		free_lane = '0;
		for (int i = RM_NUM_LANES - 1; i >= 0; i--) begin
			if (!busy_q[i]) begin
				any_free  = 1'b1;
				free_lane = RM_LANE_W'(i);
			end
		end
	end

	assign alloc  = is_monitored && any_free;
	// All lanes taken, access is lost
	assign drop_o = is_monitored && !any_free;

	assign monitor_o.monitor_ins = alloc;
	assign monitor_o.lane        = free_lane;

	//////////////////////////////
	// Lane state
	//////////////////////////////

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			busy_q <= '0;
		end else begin
			// Releases only hit busy lanes, allocation only free ones
			for (int i = 0; i < RM_NUM_LANES; i++) begin
				if (release_i[i].reset_lane)
					busy_q[release_i[i].lane] <= 1'b0;
			end
			if (alloc)
				busy_q[free_lane] <= 1'b1;
		end
	end

	// PC of each outstanding access
	always_ff @(posedge clk_i) begin
		if (alloc)
			pc_q[free_lane] <= pc_i;
	end

	assign lane_busy_o = busy_q;
	assign lane_pc_o   = pc_q;

	// Allocated lane must be free at issue and held from the next edge
	a_alloc_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
		monitor_o.monitor_ins |-> !busy_q[monitor_o.lane] ##1 busy_q[$past(monitor_o.lane)]);

endmodule

`default_nettype wire

// ==== logic/rm_lane_tracker.sv ====
// Per-lane access timer
`timescale 1ns/1ns
`default_nettype none

module rm_lane_tracker (
	input  wire                          clk_i,
	input  wire                          rst_ni,
	input  wire [rm_pkg::RM_LANE_W-1:0]  lane_id_i,
	input  rm_pkg::rm_monitor_t          mon_i,
	input  wire                          busy_i,
	input  wire                          resp_valid_i,
	input  wire [rm_pkg::RM_LANE_W-1:0]  resp_lane_i,
	input  rm_pkg::rm_cfg_t              cfg_i,
	output rm_pkg::rm_release_t          release_o
);
	import rm_pkg::*;

	// Cycles since allocation
	logic [RM_TIMER_W-1:0] timer_q;

	// Event decode
	logic alloc_here;
	logic resp_hit;
	logic timed_out;

	//////////////////////////////
	// Events
	//////////////////////////////

	// This lane picked for the issuing access
	assign alloc_here = mon_i.monitor_ins && (mon_i.lane == lane_id_i);

	// Answer tagged with this lane while it is busy
	assign resp_hit = busy_i && resp_valid_i && (resp_lane_i == lane_id_i);

	// Response in the same cycle wins over the timeout
	assign timed_out = busy_i && !resp_hit && (timer_q == cfg_i.timeout);

	//////////////////////////////
	// Timer
	//////////////////////////////

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			timer_q <= '0;
		end else if (alloc_here) begin
			// Restart at the allocation edge
			timer_q <= '0;
		end else if (busy_i) begin
			timer_q <= timer_q + RM_TIMER_W'(1);
		end
	end

	//////////////////////////////
	// Release
	//////////////////////////////

	// Combinational release frees the lane from the next edge
	always_comb begin
		release_o.reset_lane = resp_hit || timed_out;
		release_o.lane       = lane_id_i;
		release_o.timeout    = timed_out;
	end

	// Release only from a busy lane that the allocator then frees
	a_release_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
		release_o.reset_lane |-> busy_i ##1 !busy_i);

endmodule

`default_nettype wire

// ==== logic/rm_violation_log.sv ====
// Violation and drop log
`timescale 1ns/1ns
`default_nettype none

module rm_violation_log (
	input  wire                                           clk_i,
	input  wire                                           rst_ni,
	input  rm_pkg::rm_release_t [rm_pkg::RM_NUM_LANES-1:0] release_i,
	input  wire [rm_pkg::RM_NUM_LANES-1:0][rm_pkg::RM_VLEN-1:0] lane_pc_i,
	input  wire                                           drop_i,
	output logic                                          viol_o,
	output logic [rm_pkg::RM_CNT_W-1:0]                   viol_cnt_o,
	output logic [rm_pkg::RM_CNT_W-1:0]                   drop_cnt_o,
	output logic [rm_pkg::RM_VLEN-1:0]                    last_pc_o
);
	import rm_pkg::*;

	logic [RM_CNT_W-1:0] viol_cnt_q;
	logic [RM_CNT_W-1:0] drop_cnt_q;
	logic [RM_VLEN-1:0]  last_pc_q;

	// Timeouts this cycle
	logic [RM_LANE_W:0] n_timeout;
	logic [RM_VLEN-1:0] viol_pc;

	// Widened sums for saturation
	logic [RM_CNT_W:0] viol_sum;
	logic [RM_CNT_W:0] drop_sum;

	always_comb begin
		n_timeout = '0;
		viol_pc   = '0;
		// Downward walk leaves the lowest timed-out lane's PC
		for (int i = RM_NUM_LANES - 1; i >= 0; i--) begin
			if (release_i[i].reset_lane && release_i[i].timeout) begin
				n_timeout = n_timeout + (RM_LANE_W+1)'(1);
				viol_pc   = lane_pc_i[release_i[i].lane];
			end
		end

		viol_sum = {1'b0, viol_cnt_q} + (RM_CNT_W+1)'(n_timeout);
		drop_sum = {1'b0, drop_cnt_q} + (RM_CNT_W+1)'(drop_i);
	end

	assign viol_o = (n_timeout != '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			viol_cnt_q <= '0;
			drop_cnt_q <= '0;
			last_pc_q  <= '0;
		end else begin
			// Stick at all ones on carry out
			viol_cnt_q <= viol_sum[RM_CNT_W] ? '1 : viol_sum[RM_CNT_W-1:0];
			drop_cnt_q <= drop_sum[RM_CNT_W] ? '1 : drop_sum[RM_CNT_W-1:0];
			if (viol_o)
				last_pc_q <= viol_pc;
		end
	end

	assign viol_cnt_o = viol_cnt_q;
	assign drop_cnt_o = drop_cnt_q;
	assign last_pc_o  = last_pc_q;

endmodule

`default_nettype wire

// ==== logic/rm_config_regs.sv ====
// Monitor configuration registers
`timescale 1ns/1ns
`default_nettype none

module rm_config_regs (
	input  wire                          clk_i,
	input  wire                          rst_ni,
	input  wire                          reg_we_i,
	input  rm_pkg::rm_reg_e              reg_addr_i,
	input  wire [rm_pkg::RM_DATA_W-1:0]  reg_wdata_i,
	input  rm_pkg::rm_reg_e              reg_addr_rd_i,
	input  wire [rm_pkg::RM_CNT_W-1:0]   viol_cnt_i,
	input  wire [rm_pkg::RM_CNT_W-1:0]   drop_cnt_i,
	input  wire [rm_pkg::RM_VLEN-1:0]    last_pc_i,
	output rm_pkg::rm_cfg_t              cfg_o,
	output logic [rm_pkg::RM_DATA_W-1:0] rdata_o
);
	import rm_pkg::*;

	rm_cfg_t               cfg_q;
	logic [RM_TIMER_W-1:0] timeout_wr;

	// Zero timeout would fire before any answer, use 1
	assign timeout_wr = (reg_wdata_i[RM_TIMER_W-1:0] == '0) ?
		RM_TIMER_W'(1) : reg_wdata_i[RM_TIMER_W-1:0];

	//////////////////////////////
	// Write side
	//////////////////////////////

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			// Off, both classes armed
			cfg_q.enable    <= 1'b0;
			cfg_q.mon_load  <= 1'b1;
			cfg_q.mon_store <= 1'b1;
			cfg_q.timeout   <= RM_TIMEOUT_DEF;
		end else if (reg_we_i) begin
			case (reg_addr_i)
				REG_CTRL: begin
					cfg_q.enable    <= reg_wdata_i[0];
					cfg_q.mon_load  <= reg_wdata_i[1];
					cfg_q.mon_store <= reg_wdata_i[2];
				end
				REG_TIMEOUT: cfg_q.timeout <= timeout_wr;
				// Status registers are read only
				default: ;
			endcase
		end
	end

	assign cfg_o = cfg_q;

	//////////////////////////////
	// Read side
	//////////////////////////////

	always_comb begin
		case (reg_addr_rd_i)
			REG_CTRL:     rdata_o = RM_DATA_W'({cfg_q.mon_store, cfg_q.mon_load, cfg_q.enable});
			REG_TIMEOUT:  rdata_o = RM_DATA_W'(cfg_q.timeout);
			REG_VIOL_CNT: rdata_o = RM_DATA_W'(viol_cnt_i);
			REG_DROP_CNT: rdata_o = RM_DATA_W'(drop_cnt_i);
			REG_LAST_PC:  rdata_o = RM_DATA_W'(last_pc_i);
			// Unmapped
			default:      rdata_o = '0;
		endcase
	end

	// Timeout stays nonzero across every write
	a_timeout_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
		cfg_q.timeout != '0);

endmodule

`default_nettype wire

// ==== logic/rm_top.sv ====
// Runtime memory monitor top
`timescale 1ns/1ns
`default_nettype none

module rm_top (
	input  wire                          clk_i,
	input  wire                          rst_ni,
	input  rm_pkg::rm_opcode_e           opcode_i,
	input  wire [rm_pkg::RM_VLEN-1:0]    pc_i,
	input  wire                          entry_queued_i,
	input  wire                          resp_valid_i,
	input  wire [rm_pkg::RM_LANE_W-1:0]  resp_lane_i,
	input  wire                          reg_we_i,
	input  rm_pkg::rm_reg_e              reg_addr_i,
	input  wire [rm_pkg::RM_DATA_W-1:0]  reg_wdata_i,
	input  rm_pkg::rm_reg_e              reg_addr_rd_i,
	output rm_pkg::rm_monitor_t          monitor_o,
	output logic [rm_pkg::RM_NUM_LANES-1:0] lane_busy_o,
	output logic                         viol_o,
	output logic [rm_pkg::RM_DATA_W-1:0] rdata_o
);
	import rm_pkg::*;

	rm_cfg_t                              cfg;
	rm_monitor_t                          mon;
	logic [RM_NUM_LANES-1:0]              lane_busy;
	logic [RM_NUM_LANES-1:0][RM_VLEN-1:0] lane_pc;
	logic                                 drop;
	rm_release_t [RM_NUM_LANES-1:0]       lane_release;

	// Log read-back
	logic [RM_CNT_W-1:0] viol_cnt;
	logic [RM_CNT_W-1:0] drop_cnt;
	logic [RM_VLEN-1:0]  last_pc;

	rm_lane_allocator u_alloc (
		.clk_i, .rst_ni, .opcode_i, .pc_i, .entry_queued_i,
		.cfg_i(cfg), .release_i(lane_release),
		.monitor_o(mon), .lane_busy_o(lane_busy), .lane_pc_o(lane_pc), .drop_o(drop)
	);

	// One timer per lane
	for (genvar i = 0; i < RM_NUM_LANES; i++) begin : g_lane
		rm_lane_tracker u_tracker (
			.clk_i, .rst_ni, .lane_id_i(RM_LANE_W'(i)),
			.mon_i(mon), .busy_i(lane_busy[i]), .resp_valid_i, .resp_lane_i,
			.cfg_i(cfg), .release_o(lane_release[i])
		);
	end

	rm_violation_log u_log (
		.clk_i, .rst_ni, .release_i(lane_release), .lane_pc_i(lane_pc), .drop_i(drop),
		.viol_o, .viol_cnt_o(viol_cnt), .drop_cnt_o(drop_cnt), .last_pc_o(last_pc)
	);

	rm_config_regs u_regs (
		.clk_i, .rst_ni, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_addr_rd_i,
		.viol_cnt_i(viol_cnt), .drop_cnt_i(drop_cnt), .last_pc_i(last_pc),
		.cfg_o(cfg), .rdata_o
	);

	assign monitor_o   = mon;
	assign lane_busy_o = lane_busy;

endmodule

`default_nettype wire

// ==== tests/rm_tb.sv ====
// Runtime memory monitor testbench
`timescale 1ns/1ns
`default_nettype none

module rm_tb;
	import rm_pkg::*;

	// Test lengths in cycles
	localparam int N_ALLOC = 150;
	localparam int N_FILT = 120;
	localparam int N_TMO = 60;
	localparam int N_REGS = 20;
	localparam int N_RAND = 400;
	localparam int DRAIN_MAX = 64;
	localparam int BUSY_MAX = 64;
	localparam int WATCHDOG_CYCLES = 3 + N_ALLOC + N_FILT + N_TMO + N_RAND + 8 * N_REGS +
		4 * DRAIN_MAX + BUSY_MAX + 100;

	logic                          clk_i;
	logic                          rst_ni;
	rm_opcode_e                    opcode_i;
	logic [RM_VLEN-1:0]            pc_i;
	logic                          entry_queued_i;
	logic                          resp_valid_i;
	logic [RM_LANE_W-1:0]          resp_lane_i;
	logic                          reg_we_i;
	rm_reg_e                       reg_addr_i;
	logic [RM_DATA_W-1:0]          reg_wdata_i;
	rm_reg_e                       reg_addr_rd_i;
	rm_monitor_t                   monitor_o;
	logic [RM_NUM_LANES-1:0]       lane_busy_o;
	logic                          viol_o;
	logic [RM_DATA_W-1:0]          rdata_o;

	int seed;
	int errors;
	int checks;
	int tests;

	// Model state
	logic [RM_NUM_LANES-1:0] m_busy;
	logic [RM_VLEN-1:0]      m_pc [RM_NUM_LANES];
	logic [RM_TIMER_W-1:0]   m_timer [RM_NUM_LANES];
	logic [RM_CNT_W-1:0]     m_viol;
	logic [RM_CNT_W-1:0]     m_drop;
	logic [RM_VLEN-1:0]      m_last_pc;
	logic                    m_en;
	logic                    m_ld;
	logic                    m_st;
	logic [RM_TIMER_W-1:0]   m_tmo;

	rm_top dut_i (
		.clk_i(clk_i), .rst_ni(rst_ni), .opcode_i(opcode_i), .pc_i(pc_i),
		.entry_queued_i(entry_queued_i), .resp_valid_i(resp_valid_i),
		.resp_lane_i(resp_lane_i), .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i),
		.reg_wdata_i(reg_wdata_i), .reg_addr_rd_i(reg_addr_rd_i),
		.monitor_o(monitor_o), .lane_busy_o(lane_busy_o), .viol_o(viol_o), .rdata_o(rdata_o)
	);

	always #5 clk_i = ~clk_i;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic rm_opcode_e rand_opcode();
		case (rand_below(4))
			0: return OPC_LOAD;
			1: return OPC_STORE;
			2: return OPC_OP;
			default: return OPC_BRANCH;
		endcase
	endfunction

	function automatic logic [RM_CNT_W-1:0] sat_add(logic [RM_CNT_W-1:0] a, logic [RM_CNT_W-1:0] b);
		logic [RM_CNT_W:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[RM_CNT_W] ? '1 : s[RM_CNT_W-1:0];
	endfunction

	// Expected register read with fields zero-extended
	function automatic logic [31:0] model_read(logic [2:0] a);
		case (a)
			3'd0: return {29'd0, m_st, m_ld, m_en};
			3'd1: return 32'(m_tmo);
			3'd2: return 32'(m_viol);
			3'd3: return 32'(m_drop);
			3'd4: return m_last_pc;
			default: return 32'd0;
		endcase
	endfunction

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	// One clock cycle with the inputs already driven and the model stepped
	task automatic run_cycle();
		logic mon;
		logic hit;
		logic tmo;
		int free_i;
		int n_tmo;
		logic [RM_VLEN-1:0] vpc;
		logic [RM_NUM_LANES-1:0] nbusy;
		@(negedge clk_i);
		mon = entry_queued_i && m_en &&
			((opcode_i == OPC_LOAD && m_ld) || (opcode_i == OPC_STORE && m_st));
		free_i = -1;
		for (int i = RM_NUM_LANES - 1; i >= 0; i--) begin
			if (!m_busy[i])
				free_i = i;
		end
		check_value("monitor_ins", 32'(mon && free_i >= 0), 32'(monitor_o.monitor_ins));
		if (mon && free_i >= 0)
			check_value("monitor_lane", 32'(free_i), 32'(monitor_o.lane));
		check_value("rdata_o", model_read(reg_addr_rd_i), rdata_o);
		// Response beats timeout on the same lane
		nbusy = m_busy;
		n_tmo = 0;
		vpc = '0;
		for (int i = RM_NUM_LANES - 1; i >= 0; i--) begin
			hit = m_busy[i] && resp_valid_i && (resp_lane_i == RM_LANE_W'(i));
			tmo = m_busy[i] && !hit && (m_timer[i] == m_tmo);
			if (hit || tmo)
				nbusy[i] = 1'b0;
			if (tmo) begin
				n_tmo++;
				vpc = m_pc[i];
			end
			if (m_busy[i])
				m_timer[i] = m_timer[i] + 16'd1;
		end
		check_value("viol_o", 32'(n_tmo != 0), 32'(viol_o));
		if (n_tmo != 0)
			m_last_pc = vpc;
		m_viol = sat_add(m_viol, 16'(n_tmo));
		if (mon && free_i < 0)
			m_drop = sat_add(m_drop, 16'd1);
		if (mon && free_i >= 0) begin
			nbusy[free_i] = 1'b1;
			m_pc[free_i] = pc_i;
			m_timer[free_i] = '0;
		end
		// Only control and timeout are writable
		if (reg_we_i && reg_addr_i == REG_CTRL) begin
			m_en = reg_wdata_i[0];
			m_ld = reg_wdata_i[1];
			m_st = reg_wdata_i[2];
		end
		if (reg_we_i && reg_addr_i == REG_TIMEOUT)
			m_tmo = (reg_wdata_i[15:0] == '0) ? 16'd1 : reg_wdata_i[15:0];
		m_busy = nbusy;
		@(posedge clk_i);
		#1;
		check_value("lane_busy_o", 32'(m_busy), 32'(lane_busy_o));
		entry_queued_i = 1'b0;
		resp_valid_i = 1'b0;
		reg_we_i = 1'b0;
	endtask

	task automatic reg_write(rm_reg_e a, logic [31:0] d);
		reg_we_i = 1'b1;
		reg_addr_i = a;
		reg_wdata_i = d;
		run_cycle();
	endtask

	task automatic reg_read(rm_reg_e a, logic [31:0] exp);
		reg_addr_rd_i = a;
		#1;
		check_value("rdata_o", exp, rdata_o);
		run_cycle();
	endtask

	task automatic issue(rm_opcode_e op);
		entry_queued_i = 1'b1;
		opcode_i = op;
		pc_i = $random(seed);
	endtask

	// Answer random lanes until the model shows all free
	task automatic drain_lanes();
		int n;
		n = 0;
		while (m_busy != '0 && n < DRAIN_MAX) begin
			resp_valid_i = 1'b1;
			resp_lane_i = RM_LANE_W'(rand_below(RM_NUM_LANES));
			run_cycle();
			n++;
		end
		if (m_busy != '0) begin
			errors++;
			$display("lanes still busy after %0d drain cycles", DRAIN_MAX);
		end
	endtask

	task automatic report_test(string name, int err_before);
		tests++;
		$display("test %s done, %0d errors", name, errors - err_before);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_alloc_release();
		int e0;
		e0 = errors;
		reg_write(REG_TIMEOUT, 32'd40);
		reg_write(REG_CTRL, 32'd7);
		for (int n = 0; n < N_ALLOC; n++) begin
			if (rand_below(2) == 0)
				issue(rand_below(2) == 0 ? OPC_LOAD : OPC_STORE);
			resp_valid_i = (rand_below(5) < 2);
			resp_lane_i = RM_LANE_W'(rand_below(RM_NUM_LANES));
			reg_addr_rd_i = rm_reg_e'(3'(rand_below(8)));
			run_cycle();
		end
		report_test("alloc_release", e0);
	endtask

	task automatic test_filter();
		int e0;
		e0 = errors;
		for (int n = 0; n < N_FILT; n++) begin
			// Enable and class bits wander
			if (rand_below(8) == 0) begin
				reg_we_i = 1'b1;
				reg_addr_i = REG_CTRL;
				reg_wdata_i = 32'(rand_below(8));
			end
			if (rand_below(4) != 0)
				issue(rand_opcode());
			resp_valid_i = (rand_below(4) == 0);
			resp_lane_i = RM_LANE_W'(rand_below(RM_NUM_LANES));
			run_cycle();
		end
		report_test("filter", e0);
	endtask

	task automatic test_timeout();
		int e0;
		int tmo;
		int count;
		e0 = errors;
		drain_lanes();
		tmo = 2 + rand_below(4);
		reg_write(REG_TIMEOUT, 32'(tmo));
		reg_write(REG_CTRL, 32'd3);
		issue(OPC_LOAD);
		run_cycle();
		// Unanswered lane 0 holds for timeout plus one
		count = 0;
		while (lane_busy_o[0] && count < BUSY_MAX) begin
			run_cycle();
			count++;
		end
		check_value("busy_cycles", 32'(tmo + 1), 32'(count));
		for (int n = 0; n < N_TMO; n++) begin
			if (rand_below(10) < 3)
				issue(rand_below(2) == 0 ? OPC_LOAD : OPC_STORE);
			run_cycle();
		end
		reg_read(REG_VIOL_CNT, 32'(m_viol));
		reg_read(REG_LAST_PC, m_last_pc);
		report_test("timeout", e0);
	endtask

	task automatic test_drops();
		int e0;
		logic [RM_CNT_W-1:0] drop_before;
		e0 = errors;
		drain_lanes();
		reg_write(REG_TIMEOUT, 32'd200);
		reg_write(REG_CTRL, 32'd7);
		for (int n = 0; n < RM_NUM_LANES; n++) begin
			issue(OPC_LOAD);
			run_cycle();
		end
		check_value("lanes_full", 32'hf, 32'(lane_busy_o));
		drop_before = m_drop;
		for (int n = 0; n < 6; n++) begin
			issue(OPC_STORE);
			run_cycle();
		end
		reg_read(REG_DROP_CNT, 32'(drop_before) + 32'd6);
		// Free every lane by answering it
		for (int n = 0; n < RM_NUM_LANES; n++) begin
			resp_valid_i = 1'b1;
			resp_lane_i = RM_LANE_W'(n);
			run_cycle();
		end
		check_value("lanes_free", 32'd0, 32'(lane_busy_o));
		report_test("drops", e0);
	endtask

	task automatic test_regs();
		int e0;
		logic [31:0] d;
		rm_reg_e a;
		e0 = errors;
		drain_lanes();
		for (int n = 0; n < N_REGS; n++) begin
			d = $random(seed);
			reg_write(REG_CTRL, d);
			reg_read(REG_CTRL, 32'(d[2:0]));
			d = $random(seed);
			if (rand_below(4) == 0)
				d[15:0] = '0;
			reg_write(REG_TIMEOUT, d);
			reg_read(REG_TIMEOUT, (d[15:0] == '0) ? 32'd1 : 32'(d[15:0]));
			// Status registers ignore writes
			a = rm_reg_e'(3'(2 + rand_below(3)));
			reg_write(a, $random(seed));
			reg_read(a, model_read(a));
			reg_read(rm_reg_e'(3'(5 + rand_below(3))), 32'd0);
		end
		report_test("regs", e0);
	endtask

	task automatic test_random();
		int e0;
		e0 = errors;
		reg_write(REG_TIMEOUT, 32'(2 + rand_below(5)));
		for (int n = 0; n < N_RAND; n++) begin
			if (rand_below(20) == 0) begin
				reg_we_i = 1'b1;
				reg_addr_i = REG_CTRL;
				reg_wdata_i = 32'(rand_below(8));
			end
			if (rand_below(3) != 0)
				issue(rand_opcode());
			resp_valid_i = (rand_below(10) < 3);
			resp_lane_i = RM_LANE_W'(rand_below(RM_NUM_LANES));
			reg_addr_rd_i = rm_reg_e'(3'(rand_below(8)));
			run_cycle();
		end
		report_test("random", e0);
	endtask

	//////////////////////////////
	// Main and watchdog
	//////////////////////////////

	initial begin
		seed = 32'h9a669ed5;
		errors = 0;
		checks = 0;
		tests = 0;
		clk_i = 1'b0;
		rst_ni = 1'b0;
		opcode_i = OPC_OP;
		pc_i = '0;
		entry_queued_i = 1'b0;
		resp_valid_i = 1'b0;
		resp_lane_i = '0;
		reg_we_i = 1'b0;
		reg_addr_i = REG_CTRL;
		reg_wdata_i = '0;
		reg_addr_rd_i = REG_CTRL;
		// Reset values of the monitor
		m_busy = '0;
		for (int i = 0; i < RM_NUM_LANES; i++) begin
			m_pc[i] = '0;
			m_timer[i] = '0;
		end
		m_viol = '0;
		m_drop = '0;
		m_last_pc = '0;
		m_en = 1'b0;
		m_ld = 1'b1;
		m_st = 1'b1;
		m_tmo = 16'd8;
		repeat (3) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;
		test_alloc_release();
		test_filter();
		test_timeout();
		test_drops();
		test_regs();
		test_random();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
logic/rm_pkg.sv
logic/rm_lane_allocator.sv
logic/rm_lane_tracker.sv
logic/rm_violation_log.sv
logic/rm_config_regs.sv
logic/rm_top.sv
tests/rm_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert \
	--top-module rm_tb \
	-Mdir "$BUILD_DIR" -o rm_tb_sim \
	-f project.f

"./$BUILD_DIR/rm_tb_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
	exit 1
fi
exit 0
